//--- hdl/apu_sq_defs.svh
/* Width and threshold macros for the pulse channel */

`ifndef APU_SQ_DEFS_SVH
`define APU_SQ_DEFS_SVH

// Period register, timer and sweep adder width
`define SQ_PERIOD_W 11

// Volume, envelope decay level and output sample
`define SQ_VOL_W 4

// Length counter
`define SQ_LEN_W 8

// Periods below this value silence the channel
`define SQ_MIN_PERIOD 8

`endif

//--- hdl/apu_sq_pkg.sv
/* Register byte views of the pulse channel: control, sweep,
   period high / length index, and the union over them */

`include "apu_sq_defs.svh"

package apu_sq_pkg;

	typedef struct packed {
		logic [1:0] duty;
		logic halt_loop;		// Length halt and envelope loop
		logic const_vol;
		logic [`SQ_VOL_W-1:0] vol;	// Also the envelope divider period
	} sq_ctrl_t;

	typedef struct packed {
		logic enable;
		logic [2:0] period;
		logic negate;
		logic [2:0] shift;
	} sq_sweep_t;

	typedef struct packed {
		logic [4:0] len_idx;
		logic [2:0] period_hi;
	} sq_hi_t;

	typedef union packed {
		sq_ctrl_t ctrl;		// Register 0
		sq_sweep_t sweep;	// Register 1
		logic [7:0] raw;	// Register 2, period low byte
		sq_hi_t hi;		// Register 3
	} sq_reg_u;

endpackage

//--- hdl/sq_freq_unit.sv
/* Period register, period timer, barrel shifter and sweep adder */

`timescale 1ns/100ps
`include "apu_sq_defs.svh"

module sq_freq_unit
	import apu_sq_pkg::*;
#(
	parameter bit NEG_ONES_COMP = 1'b1
) (
	input logic aclk,
	input logic rst_n,
	input logic reg1_wr,
	input logic reg2_wr,
	input logic reg3_wr,
	input sq_reg_u wr_data,
	input logic period_update,
	output logic period_tick,
	output logic target_mute,
	output logic shift_nonzero
);

	logic [`SQ_PERIOD_W-1:0] period;
	logic [`SQ_PERIOD_W-1:0] timer;
	logic negate;
	logic [2:0] shift;

	logic [`SQ_PERIOD_W-1:0] sh1;
	logic [`SQ_PERIOD_W-1:0] sh2;
	logic [`SQ_PERIOD_W-1:0] shifted;
	logic [`SQ_PERIOD_W:0] addend;
	logic carry_in;
	logic [`SQ_PERIOD_W:0] sum;

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			negate <= 1'b0;
			shift <= '0;
		end else if (reg1_wr) begin
			negate <= wr_data.sweep.negate;
			shift <= wr_data.sweep.shift;
		end
	end

	// Sweep load wins over register writes
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			period <= '0;
		end else if (period_update) begin
			period <= sum[`SQ_PERIOD_W-1:0];
		end else begin
			if (reg2_wr)
				period[7:0] <= wr_data.raw;
			if (reg3_wr)
				period[`SQ_PERIOD_W-1:8] <= wr_data.hi.period_hi;
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			timer <= '0;
			period_tick <= 1'b0;
		end else if (timer == '0) begin
			timer <= period;
			period_tick <= 1'b1;
		end else begin
			timer <= timer - 1'b1;
			period_tick <= 1'b0;
		end
	end

	// Three-stage barrel shifter
	assign sh1 = shift[0] ? (period >> 1) : period;
	assign sh2 = shift[1] ? (sh1 >> 2) : sh1;
	assign shifted = shift[2] ? (sh2 >> 4) : sh2;

	// Ones' complement leaves the carry off, so negation costs an extra 1
	assign addend = negate ? ~{1'b0, shifted} : {1'b0, shifted};
	assign carry_in = negate & ~NEG_ONES_COMP;
	assign sum = {1'b0, period} + addend + {{`SQ_PERIOD_W{1'b0}}, carry_in};

	assign target_mute = (period < `SQ_MIN_PERIOD) || (!negate && sum[`SQ_PERIOD_W]);
	assign shift_nonzero = |shift;

endmodule

//--- hdl/sq_sweep_unit.sv
/* Sweep divider, reload flag and the period-update decision */

`timescale 1ns/100ps

module sq_sweep_unit
	import apu_sq_pkg::*;
(
	input logic aclk,
	input logic rst_n,
	input logic reg1_wr,
	input sq_reg_u wr_data,
	input logic half_frame,
	input logic target_mute,
	input logic shift_nonzero,
	output logic period_update
);

	logic sweep_en;
	logic [2:0] div_period;
	logic [2:0] divider;
	logic reload;
	logic div_zero;

	assign div_zero = (divider == '0);

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_en <= 1'b0;
			div_period <= '0;
		end else if (reg1_wr) begin
			sweep_en <= wr_data.sweep.enable;
			div_period <= wr_data.sweep.period;
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			divider <= '0;
		end else if (half_frame) begin
			if (div_zero || reload)
				divider <= div_period;
			else
				divider <= divider - 1'b1;
		end
	end

	// A register write sets the flag even on a half-frame
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			reload <= 1'b0;
		else if (reg1_wr)
			reload <= 1'b1;
		else if (half_frame)
			reload <= 1'b0;
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			period_update <= 1'b0;
		else
			period_update <= half_frame && div_zero && sweep_en &&
				shift_nonzero && !target_mute;
	end

endmodule

//--- hdl/sq_envelope_length.sv
/* Envelope divider and decay level, and the length counter
   with its load table */

`timescale 1ns/100ps
`include "apu_sq_defs.svh"

module sq_envelope_length
	import apu_sq_pkg::*;
(
	input logic aclk,
	input logic rst_n,
	input logic reg0_wr,
	input logic reg3_wr,
	input sq_reg_u wr_data,
	input logic enable,
	input logic quarter_frame,
	input logic half_frame,
	output logic [`SQ_VOL_W-1:0] volume,
	output logic length_active
);

	localparam logic [`SQ_LEN_W-1:0] LEN_TAB [0:31] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	logic halt_loop;
	logic const_vol;
	logic [`SQ_VOL_W-1:0] vol;
	logic start;
	logic [`SQ_VOL_W-1:0] env_div;
	logic [`SQ_VOL_W-1:0] decay;
	logic [`SQ_LEN_W-1:0] len_cnt;

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			halt_loop <= 1'b0;
			const_vol <= 1'b0;
			vol <= '0;
		end else if (reg0_wr) begin
			halt_loop <= wr_data.ctrl.halt_loop;
			const_vol <= wr_data.ctrl.const_vol;
			vol <= wr_data.ctrl.vol;
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			start <= 1'b0;
		else if (reg3_wr)
			start <= 1'b1;
		else if (quarter_frame)
			start <= 1'b0;
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			env_div <= '0;
			decay <= '0;
		end else if (quarter_frame) begin
			if (start) begin
				env_div <= vol;
				decay <= '1;
			end else if (env_div == '0) begin
				env_div <= vol;
				if (decay != '0)
					decay <= decay - 1'b1;
				else if (halt_loop)
					decay <= '1;		// Loop back to 15
			end else begin
				env_div <= env_div - 1'b1;
			end
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			len_cnt <= '0;
		else if (!enable)
			len_cnt <= '0;
		else if (reg3_wr)
			len_cnt <= LEN_TAB[wr_data.hi.len_idx];
		else if (half_frame && len_cnt != '0 && !halt_loop)
			len_cnt <= len_cnt - 1'b1;
	end

	assign volume = const_vol ? vol : decay;
	assign length_active = (len_cnt != '0);

endmodule

//--- hdl/sq_duty_seq.sv
/* Duty register and eight-step waveform sequencer */

`timescale 1ns/100ps

module sq_duty_seq
	import apu_sq_pkg::*;
(
	input logic aclk,
	input logic rst_n,
	input logic reg0_wr,
	input logic reg3_wr,
	input sq_reg_u wr_data,
	input logic period_tick,
	output logic wave
);

	// Step 0 is the leftmost bit of each pattern
	localparam logic [7:0] DUTY_TAB [0:3] = '{
		8'b0100_0000, 8'b0110_0000, 8'b0111_1000, 8'b1001_1111
	};

	logic [1:0] duty;
	logic [2:0] idx;

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			duty <= '0;
		else if (reg0_wr)
			duty <= wr_data.ctrl.duty;
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (reg3_wr)
			idx <= '0;		// Restart the pattern
		else if (period_tick)
			idx <= idx - 1'b1;
	end

	assign wave = DUTY_TAB[duty][~idx];

endmodule

//--- hdl/sq_channel.sv
/* Pulse channel top level with register decode and the
   output sample gate */

`timescale 1ns/100ps
`include "apu_sq_defs.svh"

module sq_channel
	import apu_sq_pkg::*;
#(
	parameter bit NEG_ONES_COMP = 1'b1	// 1 for channel 0, 0 for channel 1
) (
	input logic aclk,
	input logic rst_n,
	input logic wr_en,
	input logic [1:0] wr_addr,
	input sq_reg_u wr_data,
	input logic enable,
	input logic quarter_frame,
	input logic half_frame,
	output logic [`SQ_VOL_W-1:0] sample,
	output logic length_active
);

	logic reg0_wr;
	logic reg1_wr;
	logic reg2_wr;
	logic reg3_wr;
	logic period_tick;
	logic target_mute;
	logic shift_nonzero;
	logic period_update;
	logic wave;
	logic [`SQ_VOL_W-1:0] volume;

	assign reg0_wr = wr_en && (wr_addr == 2'd0);
	assign reg1_wr = wr_en && (wr_addr == 2'd1);
	assign reg2_wr = wr_en && (wr_addr == 2'd2);
	assign reg3_wr = wr_en && (wr_addr == 2'd3);

	sq_freq_unit #(
		.NEG_ONES_COMP(NEG_ONES_COMP)
	) freq_i (
		.aclk(aclk),
		.rst_n(rst_n),
		.reg1_wr(reg1_wr),
		.reg2_wr(reg2_wr),
		.reg3_wr(reg3_wr),
		.wr_data(wr_data),
		.period_update(period_update),
		.period_tick(period_tick),
		.target_mute(target_mute),
		.shift_nonzero(shift_nonzero)
	);

	sq_sweep_unit sweep_i (
		.aclk(aclk),
		.rst_n(rst_n),
		.reg1_wr(reg1_wr),
		.wr_data(wr_data),
		.half_frame(half_frame),
		.target_mute(target_mute),
		.shift_nonzero(shift_nonzero),
		.period_update(period_update)
	);

	sq_duty_seq duty_i (
		.aclk(aclk),
		.rst_n(rst_n),
		.reg0_wr(reg0_wr),
		.reg3_wr(reg3_wr),
		.wr_data(wr_data),
		.period_tick(period_tick),
		.wave(wave)
	);

	sq_envelope_length env_i (
		.aclk(aclk),
		.rst_n(rst_n),
		.reg0_wr(reg0_wr),
		.reg3_wr(reg3_wr),
		.wr_data(wr_data),
		.enable(enable),
		.quarter_frame(quarter_frame),
		.half_frame(half_frame),
		.volume(volume),
		.length_active(length_active)
	);

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else if (wave && length_active && !target_mute)
			sample <= volume;
		else
			sample <= '0;
	end

endmodule

//--- testbench/sq_channel_assertions.sv
/* Concurrent checks on the pulse channel ports, bound into sq_channel */

`timescale 1ns/100ps
`include "apu_sq_defs.svh"

module sq_channel_assertions (
	input logic aclk,
	input logic rst_n,
	input logic wr_en,
	input logic [1:0] wr_addr,
	input logic enable,
	input logic [`SQ_VOL_W-1:0] sample,
	input logic length_active
);

	// Sample register trails the length counter by one cycle
	property silent_when_expired;
		@(posedge aclk) disable iff (!rst_n)
			!length_active |=> (sample == '0);
	endproperty

	property idle_in_reset;
		@(posedge aclk) !rst_n |-> (!length_active && sample == '0);
	endproperty

	// Every table entry is nonzero
	property length_loaded;
		@(posedge aclk) disable iff (!rst_n)
			(wr_en && wr_addr == 2'd3 && enable) |=> (length_active || !enable);
	endproperty

	assert property (silent_when_expired)
		else $error("sample is nonzero while the length counter is empty");

	assert property (idle_in_reset)
		else $error("length counter or sample active during reset");

	assert property (length_loaded)
		else $error("register 3 write left the length counter empty");

endmodule

bind sq_channel sq_channel_assertions assert_i (
	.aclk(aclk),
	.rst_n(rst_n),
	.wr_en(wr_en),
	.wr_addr(wr_addr),
	.enable(enable),
	.sample(sample),
	.length_active(length_active)
);

//--- testbench/tb_sq_channel.sv
/* Directed testbench for the pulse channel: clock, reset, register
   writes, compare tasks, timeout and the five test tasks */

`timescale 1ns/100ps
`include "apu_sq_defs.svh"

module tb_sq_channel
	import apu_sq_pkg::*;
();

	localparam bit NEG_ONES_COMP = 1'b1;
	localparam int MAX_CYCLES = 20000;	// Tests need about 10k cycles
	localparam int LEN_TAB [0:31] = '{10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12,
		26, 14, 12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30};

	logic aclk;
	logic rst_n;
	logic wr_en;
	logic [1:0] wr_addr;
	sq_reg_u wr_data;
	logic enable;
	logic quarter_frame;
	logic half_frame;
	logic [`SQ_VOL_W-1:0] sample;
	logic length_active;

	integer seed;
	int cycle_cnt = 0;
	logic [`SQ_PERIOD_W-1:0] cur_period;
	logic [`SQ_VOL_W-1:0] vol_v;

	sq_channel #(
		.NEG_ONES_COMP(NEG_ONES_COMP)
	) dut_i (
		.aclk(aclk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.enable(enable),
		.quarter_frame(quarter_frame),
		.half_frame(half_frame),
		.sample(sample),
		.length_active(length_active)
	);

	always #50 aclk = ~aclk;

	always @(posedge aclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			fail_stop($sformatf("timeout: tests did not finish in %0d cycles", cycle_cnt));
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_sample(input string name, input logic [`SQ_VOL_W-1:0] got, exp);
		if (got !== exp)
			fail_stop($sformatf("error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp)
			fail_stop($sformatf("error at %0t: %s = %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, exp);
		if (got != exp)
			fail_stop($sformatf("error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic sq_reg_u ctrl_word(input logic [1:0] duty, input logic halt,
			input logic cv, input logic [`SQ_VOL_W-1:0] vol);
		sq_reg_u u;
		u.ctrl = '{duty, halt, cv, vol};
		return u;
	endfunction

	function automatic sq_reg_u sweep_word(input logic en, input logic [2:0] per,
			input logic neg, input logic [2:0] sh);
		sq_reg_u u;
		u.sweep = '{en, per, neg, sh};
		return u;
	endfunction

	function automatic sq_reg_u hi_word(input logic [4:0] idx, input logic [2:0] hi);
		sq_reg_u u;
		u.hi = '{idx, hi};
		return u;
	endfunction

	function automatic int duty_ones(input int duty);
		case (duty)
			0: return 1;
			1: return 2;
			2: return 4;
			default: return 6;
		endcase
	endfunction

	function automatic int sweep_target(input int p, input int s, input bit neg);
		int delta;
		delta = p >> s;
		if (!neg)
			return p + delta;
		return NEG_ONES_COMP ? p - delta - 1 : p - delta;	// Ones' complement costs one more
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge aclk);
	endtask

	task automatic write_reg(input logic [1:0] addr, input sq_reg_u data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge aclk);
		wr_en = 1'b0;
	endtask

	task automatic pulse_half_frame();
		half_frame = 1'b1;
		@(negedge aclk);
		half_frame = 1'b0;
	endtask

	task automatic pulse_quarter(input int n);
		repeat (n) begin
			quarter_frame = 1'b1;
			@(negedge aclk);
			quarter_frame = 1'b0;
		end
	endtask

	// Old timer count has to drain before the new period runs
	task automatic set_period(input logic [`SQ_PERIOD_W-1:0] p, input logic [4:0] len_idx);
		sq_reg_u lo;
		lo.raw = p[7:0];
		write_reg(2'd2, lo);
		write_reg(2'd3, hi_word(len_idx, p[`SQ_PERIOD_W-1:8]));
		wait_cycles(cur_period + 3);
		cur_period = p;
	endtask

	task automatic count_level(input int cycles, input logic [`SQ_VOL_W-1:0] level,
			output int hits);
		hits = 0;
		repeat (cycles) begin
			if (sample == level)
				hits++;
			else
				check_sample("sample", sample, '0);
			@(negedge aclk);
		end
	endtask

	task automatic measure_peak(input int cycles, output logic [`SQ_VOL_W-1:0] peak);
		peak = '0;
		wait_cycles(2);		// Skip the stale sample
		repeat (cycles) begin
			if (sample > peak)
				peak = sample;
			@(negedge aclk);
		end
	endtask

	task automatic run_length(input logic [`SQ_VOL_W-1:0] level, output int len);
		len = 0;
		while (sample == level)
			@(negedge aclk);
		while (sample != level)
			@(negedge aclk);
		while (sample == level) begin
			len++;
			@(negedge aclk);
		end
	endtask

	task automatic check_silent(input int cycles);
		repeat (cycles) begin
			check_sample("sample", sample, '0);
			check_flag("length_active", length_active, 1'b1);
			@(negedge aclk);
		end
	endtask

	task automatic duty_shape_test();
		int hits;
		write_reg(2'd1, sweep_word(1'b0, 3'd0, 1'b0, 3'd0));
		write_reg(2'd0, ctrl_word(2'd0, 1'b1, 1'b1, vol_v));
		set_period(11'd20, 5'd0);
		for (int d = 0; d < 4; d++) begin
			write_reg(2'd0, ctrl_word(2'(d), 1'b1, 1'b1, vol_v));
			wait_cycles(2);
			count_level(32 * 21, vol_v, hits);	// Four full patterns
			check_count("duty high cycles", hits, 4 * 21 * duty_ones(d));
		end
	endtask

	task automatic period_mute_test();
		set_period(11'd7, 5'd0);
		check_silent(200);
		write_reg(2'd1, sweep_word(1'b0, 3'd0, 1'b0, 3'd1));
		set_period(11'h600, 5'd0);	// Add-mode target 0x900
		check_silent(200);
		write_reg(2'd1, sweep_word(1'b0, 3'd0, 1'b0, 3'd0));
		set_period(11'd8, 5'd0);
	endtask

	task automatic length_counter_test();
		int n;
		n = LEN_TAB[5];
		write_reg(2'd0, ctrl_word(2'd3, 1'b0, 1'b1, vol_v));
		write_reg(2'd3, hi_word(5'd5, cur_period[`SQ_PERIOD_W-1:8]));
		check_flag("length_active", length_active, 1'b1);
		for (int i = 1; i <= n; i++) begin
			pulse_half_frame();
			check_flag("length_active", length_active, i < n);
		end
		write_reg(2'd0, ctrl_word(2'd3, 1'b1, 1'b1, vol_v));
		write_reg(2'd3, hi_word(5'd0, cur_period[`SQ_PERIOD_W-1:8]));
		repeat (LEN_TAB[0] + 2) begin
			pulse_half_frame();
			check_flag("length_active", length_active, 1'b1);
		end
		enable = 1'b0;
		@(negedge aclk);
		check_flag("length_active", length_active, 1'b0);
		enable = 1'b1;
	endtask

	task automatic envelope_test();
		integer rnd;
		int d_div;
		logic [`SQ_VOL_W-1:0] peak;
		rnd = $random(seed);
		d_div = rnd & 3;
		write_reg(2'd0, ctrl_word(2'd3, 1'b0, 1'b0, 4'(d_div)));
		set_period(11'd8, 5'd1);
		pulse_quarter(1);
		measure_peak(72, peak);
		check_sample("peak sample", peak, 4'd15);
		for (int lvl = 14; lvl >= 0; lvl--) begin
			pulse_quarter(d_div + 1);
			measure_peak(72, peak);
			check_sample("peak sample", peak, 4'(lvl));
		end
		pulse_quarter(d_div + 1);	// Holds at 0 without loop
		measure_peak(72, peak);
		check_sample("peak sample", peak, 4'd0);
		write_reg(2'd0, ctrl_word(2'd3, 1'b1, 1'b0, 4'(d_div)));
		pulse_quarter(d_div + 1);
		measure_peak(72, peak);
		check_sample("peak sample", peak, 4'd15);
	endtask

	task automatic sweep_case(input logic [`SQ_PERIOD_W-1:0] p, input logic [2:0] s,
			input logic neg);
		int target;
		int len;
		target = sweep_target(p, s, neg);
		set_period(p, 5'd0);
		write_reg(2'd1, sweep_word(1'b1, 3'd0, neg, s));
		pulse_half_frame();
		wait_cycles(p + 4);
		run_length(vol_v, len);		// Duty 0 is high for one step
		check_count("duty high run", len, target + 1);
		cur_period = 11'(target);
	endtask

	task automatic sweep_test();
		write_reg(2'd0, ctrl_word(2'd0, 1'b1, 1'b1, vol_v));
		sweep_case(11'd100, 3'd1, 1'b0);
		sweep_case(11'd100, 3'd2, 1'b1);
	endtask

	initial begin
		integer rnd;
		aclk = 1'b0;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		enable = 1'b0;
		quarter_frame = 1'b0;
		half_frame = 1'b0;
		seed = 35381;
		cur_period = '0;
		repeat (16) @(posedge aclk);
		@(negedge aclk);
		rst_n = 1'b1;
		enable = 1'b1;
		@(negedge aclk);
		rnd = $random(seed);
		vol_v = 4'(rnd);
		if (vol_v == '0)
			vol_v = 4'd9;
		duty_shape_test();
		period_mute_test();
		length_counter_test();
		envelope_test();
		sweep_test();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/apu_sq_pkg.sv
hdl/sq_freq_unit.sv
hdl/sq_sweep_unit.sv
hdl/sq_envelope_length.sv
hdl/sq_duty_seq.sv
hdl/sq_channel.sv
testbench/sq_channel_assertions.sv
testbench/tb_sq_channel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the pulse channel testbench with Verilator and run it.
# A failing run ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_sq_channel \
	-Mdir obj_dir \
	-o sim_sq_channel

./obj_dir/sim_sq_channel
